// File: tb.f
+incdir+dv
logic/srt_div_pkg.sv
logic/srt_lzc.sv
logic/srt_operand_prep.sv
logic/srt_iterate.sv
logic/srt_result.sv
logic/srt_ctrl.sv
logic/srt_divider.sv
dv/srt_divider_tb.sv

// File: Bender.yml
package:
  name: srt_divider

sources:
  - logic/srt_div_pkg.sv
  - logic/srt_lzc.sv
  - logic/srt_operand_prep.sv
  - logic/srt_iterate.sv
  - logic/srt_result.sv
  - logic/srt_ctrl.sv
  - logic/srt_divider.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/srt_divider_tb.sv

// File: dv/srt_vectors.svh
// directed stimulus table for the divider testbench, included inside the testbench module
`ifndef SRT_VECTORS_SVH
`define SRT_VECTORS_SVH

task automatic load_table();
    // each row holds dividend, divisor, is_signed, expected quotient,
    // expected remainder, expected div_zero and a label

    // unsigned
    add_row(32'h00000064, 32'h00000007, 1'b0, 32'h0000000e, 32'h00000002, 1'b0, "u 100/7");
    add_row(32'hffffffff, 32'h00000001, 1'b0, 32'hffffffff, 32'h00000000, 1'b0, "u max/1");
    add_row(32'hffffffff, 32'h00000010, 1'b0, 32'h0fffffff, 32'h0000000f, 1'b0, "u max/16");
    add_row(32'h80000000, 32'h00000003, 1'b0, 32'h2aaaaaaa, 32'h00000002, 1'b0, "u msb/3");
    add_row(32'hfffffffe, 32'hffffffff, 1'b0, 32'h00000000, 32'hfffffffe, 1'b0, "u same lzc");
    add_row(32'h12345678, 32'h12345678, 1'b0, 32'h00000001, 32'h00000000, 1'b0, "u equal");
    add_row(32'h80000001, 32'h80000000, 1'b0, 32'h00000001, 32'h00000001, 1'b0, "u msb+1/msb");
    add_row(32'h000f4240, 32'h000003e8, 1'b0, 32'h000003e8, 32'h00000000, 1'b0, "u 1e6/1000");
    add_row(32'hffffffff, 32'h00010000, 1'b0, 32'h0000ffff, 32'h0000ffff, 1'b0, "u max/64k");
    add_row(32'h00003039, 32'h00000064, 1'b0, 32'h0000007b, 32'h0000002d, 1'b0, "u 12345/100");
    add_row(32'hffffffff, 32'h80000000, 1'b0, 32'h00000001, 32'h7fffffff, 1'b0, "u max/msb");

    // signed over all four sign pairs and the extremes
    add_row(32'h00000064, 32'h00000007, 1'b1, 32'h0000000e, 32'h00000002, 1'b0, "s +/+");
    add_row(32'h00000064, 32'hfffffff9, 1'b1, 32'hfffffff2, 32'h00000002, 1'b0, "s +/-");
    add_row(32'hffffff9c, 32'h00000007, 1'b1, 32'hfffffff2, 32'hfffffffe, 1'b0, "s -/+");
    add_row(32'hffffff9c, 32'hfffffff9, 1'b1, 32'h0000000e, 32'hfffffffe, 1'b0, "s -/-");
    add_row(32'h80000000, 32'hffffffff, 1'b1, 32'h80000000, 32'h00000000, 1'b0, "s min/-1");
    add_row(32'h80000000, 32'h00000002, 1'b1, 32'hc0000000, 32'h00000000, 1'b0, "s min/2");
    add_row(32'h80000000, 32'h00000007, 1'b1, 32'hedb6db6e, 32'hfffffffe, 1'b0, "s min/7");
    add_row(32'hffffffff, 32'hffffffff, 1'b1, 32'h00000001, 32'h00000000, 1'b0, "s -1/-1");
    add_row(32'h7fffffff, 32'h80000000, 1'b1, 32'h00000000, 32'h7fffffff, 1'b0, "s max/min");

    // short path
    add_row(32'h00000005, 32'h00000009, 1'b0, 32'h00000000, 32'h00000005, 1'b0, "short u");
    add_row(32'hfffffffd, 32'h00000007, 1'b1, 32'h00000000, 32'hfffffffd, 1'b0, "short s");
    add_row(32'h0000ffff, 32'h00010000, 1'b0, 32'h00000000, 32'h0000ffff, 1'b0, "short 64k");
    add_row(32'h00000000, 32'h00000005, 1'b0, 32'h00000000, 32'h00000000, 1'b0, "zero/5");

    // divide by zero
    add_row(32'h12345678, 32'h00000000, 1'b0, 32'hffffffff, 32'h12345678, 1'b1, "dz u");
    add_row(32'h80000000, 32'h00000000, 1'b1, 32'hffffffff, 32'h80000000, 1'b1, "dz s");
    add_row(32'h00000000, 32'h00000000, 1'b0, 32'hffffffff, 32'h00000000, 1'b1, "dz 0/0");
endtask

`endif

// File: dv/srt_divider_tb.sv
// self-checking testbench driving the SRT divider with the stimulus table and random rows
`timescale 1ns/1ps
`default_nettype none

module srt_divider_tb;

    localparam int WIDTH           = srt_div_pkg::DATA_WIDTH;
    localparam int ACK_TIMEOUT     = 4 * WIDTH + 20;
    localparam int RELEASE_TIMEOUT = 8;
    localparam int RANDOM_ROWS     = 40;

    logic             clk;
    logic             reset;
    logic             req;
    logic [WIDTH-1:0] dividend;
    logic [WIDTH-1:0] divisor;
    logic             is_signed;
    logic             ack;
    logic [WIDTH-1:0] quotient;
    logic [WIDTH-1:0] remainder;
    logic             div_zero;

    // one entry per test from the table and the random generator
    logic [WIDTH-1:0] row_dividend [$];
    logic [WIDTH-1:0] row_divisor [$];
    logic             row_signed [$];
    logic [WIDTH-1:0] row_quotient [$];
    logic [WIDTH-1:0] row_remainder [$];
    logic             row_div_zero [$];
    string            row_label [$];

    integer seed;
    int     check_errors;
    int     monitor_errors;
    int     tests_run;
    int     tests_failed;
    logic   timed_out;
    logic   last_ack;

    srt_divider #(.WIDTH(WIDTH)) u_srt_divider (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .dividend  (dividend),
        .divisor   (divisor),
        .is_signed (is_signed),
        .ack       (ack),
        .quotient  (quotient),
        .remainder (remainder),
        .div_zero  (div_zero)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ack may only rise while a request is pending
    always @(negedge clk) begin
        if (reset) begin
            last_ack = 1'b0;
        end else begin
            if (ack && !last_ack && !req) begin
                $display("ack rose at %0t while req was low", $time);
                monitor_errors++;
            end
            last_ack = ack;
        end
    end

    task automatic add_row(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                           input logic s, input logic [WIDTH-1:0] q,
                           input logic [WIDTH-1:0] r, input logic dz, input string label);
        row_dividend.push_back(a);
        row_divisor.push_back(b);
        row_signed.push_back(s);
        row_quotient.push_back(q);
        row_remainder.push_back(r);
        row_div_zero.push_back(dz);
        row_label.push_back(label);
    endtask

    `include "srt_vectors.svh"

    // quotient truncates toward zero and remainder takes the dividend's sign
    task automatic reference_divide(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                                    input logic s, output logic [WIDTH-1:0] q,
                                    output logic [WIDTH-1:0] r, output logic dz);
        logic             a_neg;
        logic             b_neg;
        logic [WIDTH-1:0] a_mag;
        logic [WIDTH-1:0] b_mag;
        a_neg = s && a[WIDTH-1];
        b_neg = s && b[WIDTH-1];
        if (b == '0) begin
            q  = '1;
            r  = a;
            dz = 1'b1;
        end else begin
            a_mag = a_neg ? -a : a;
            b_mag = b_neg ? -b : b;
            q     = a_mag / b_mag;
            r     = a_mag % b_mag;
            if (a_neg != b_neg) begin
                q = -q;
            end
            if (a_neg) begin
                r = -r;
            end
            dz = 1'b0;
        end
    endtask

    task automatic add_random_rows(input int count);
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [4:0]       shift;
        logic             s;
        logic [WIDTH-1:0] q;
        logic [WIDTH-1:0] r;
        logic             dz;
        for (int i = 0; i < count; i++) begin
            a     = $random(seed);
            b     = $random(seed);
            shift = $random(seed);
            s     = $random(seed);
            // narrow divisors give long iteration runs
            b = b >> shift;
            reference_divide(a, b, s, q, r, dz);
            add_row(a, b, s, q, r, dz, "random");
        end
    endtask

    task automatic check_quotient(input logic [WIDTH-1:0] expected,
                                  input logic [WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED quotient: expected %h, got %h", expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_remainder(input logic [WIDTH-1:0] expected,
                                   input logic [WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED remainder: expected %h, got %h", expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_div_zero(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED div_zero: expected %h, got %h", expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_results(input int idx);
        check_quotient(row_quotient[idx], quotient);
        check_remainder(row_remainder[idx], remainder);
        check_div_zero(row_div_zero[idx], div_zero);
    endtask

    task automatic run_test(input int idx);
        int cycles;
        int errors_before;
        errors_before = check_errors;
        @(posedge clk);
        #1;
        dividend  = row_dividend[idx];
        divisor   = row_divisor[idx];
        is_signed = row_signed[idx];
        req       = 1'b1;
        cycles    = 0;
        while (!ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            $display("test %0d (%s): ack never rose within %0d cycles",
                     idx, row_label[idx], ACK_TIMEOUT);
            timed_out = 1'b1;
        end else begin
            check_results(idx);
            // results must hold under back-pressure
            repeat (idx % 4) begin
                @(negedge clk);
                if (!ack) begin
                    $display("test %0d: ack dropped while req was still high", idx);
                    check_errors++;
                end
                check_results(idx);
            end
            @(posedge clk);
            #1;
            req    = 1'b0;
            cycles = 0;
            while (ack && cycles < RELEASE_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (ack) begin
                $display("test %0d (%s): ack still high %0d cycles after req dropped",
                         idx, row_label[idx], RELEASE_TIMEOUT);
                timed_out = 1'b1;
            end
        end
        tests_run++;
        if (check_errors != errors_before || timed_out) begin
            tests_failed++;
            $display("test %0d (%s): fail", idx, row_label[idx]);
        end else begin
            $display("test %0d (%s): ok", idx, row_label[idx]);
        end
    endtask

    initial begin
        seed           = 32'ha40c_18ea;
        check_errors   = 0;
        monitor_errors = 0;
        tests_run      = 0;
        tests_failed   = 0;
        timed_out      = 1'b0;
        reset          = 1'b1;
        req            = 1'b0;
        dividend       = '0;
        divisor        = '0;
        is_signed      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("FAILED ack: expected 0, got %h", ack);
            check_errors++;
        end
        check_quotient('0, quotient);
        check_remainder('0, remainder);
        check_div_zero(1'b0, div_zero);
        load_table();
        add_random_rows(RANDOM_ROWS);
        for (int i = 0; i < row_dividend.size() && !timed_out; i++) begin
            run_test(i);
        end
        $display("tests run %0d, failed %0d, check errors %0d, monitor errors %0d",
                 tests_run, tests_failed, check_errors, monitor_errors);
        if (check_errors == 0 && monitor_errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/srt_divider.sv
// SRT divider top level tying the sequencer to the operand, iteration and result stages
`timescale 1ns/1ps
`default_nettype none

module srt_divider #(
    parameter int WIDTH = srt_div_pkg::DATA_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             req,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    input  logic             is_signed,
    output logic             ack,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder,
    output logic             div_zero
);

    localparam int CW = srt_div_pkg::count_bits(WIDTH);

    srt_div_pkg::srt_phase_t phase;
    logic             div_by_zero;
    logic             short_path;
    logic             iter_done;
    logic [WIDTH:0]   norm_dividend;
    logic [WIDTH:0]   norm_divisor;
    logic [WIDTH:0]   partial_rem;
    logic [WIDTH-1:0] pos_q;
    logic [WIDTH-1:0] neg_q;
    logic [CW-1:0]    rounds;
    logic [CW-1:0]    shift_total;
    logic             q_neg;
    logic             r_neg;

    srt_ctrl u_srt_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .div_by_zero (div_by_zero),
        .short_path  (short_path),
        .iter_done   (iter_done),
        .ack         (ack),
        .phase       (phase)
    );

    srt_operand_prep #(.WIDTH(WIDTH)) u_srt_operand_prep (
        .clk           (clk),
        .reset         (reset),
        .phase         (phase),
        .dividend      (dividend),
        .divisor       (divisor),
        .is_signed     (is_signed),
        .div_by_zero   (div_by_zero),
        .short_path    (short_path),
        .norm_dividend (norm_dividend),
        .norm_divisor  (norm_divisor),
        .rounds        (rounds),
        .shift_total   (shift_total),
        .q_neg         (q_neg),
        .r_neg         (r_neg)
    );

    srt_iterate #(.WIDTH(WIDTH)) u_srt_iterate (
        .clk           (clk),
        .reset         (reset),
        .phase         (phase),
        .norm_dividend (norm_dividend),
        .norm_divisor  (norm_divisor),
        .rounds        (rounds),
        .iter_done     (iter_done),
        .partial_rem   (partial_rem),
        .pos_q         (pos_q),
        .neg_q         (neg_q)
    );

    srt_result #(.WIDTH(WIDTH)) u_srt_result (
        .clk          (clk),
        .reset        (reset),
        .phase        (phase),
        .dividend     (dividend),
        .partial_rem  (partial_rem),
        .norm_divisor (norm_divisor),
        .pos_q        (pos_q),
        .neg_q        (neg_q),
        .shift_total  (shift_total),
        .q_neg        (q_neg),
        .r_neg        (r_neg),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_zero     (div_zero)
    );

endmodule

`default_nettype wire

// File: logic/srt_ctrl.sv
// req/ack handshake and phase sequencer that steps the divider datapath
`timescale 1ns/1ps
`default_nettype none

module srt_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req,
    input  logic                    div_by_zero,
    input  logic                    short_path,
    input  logic                    iter_done,
    output logic                    ack,
    output srt_div_pkg::srt_phase_t phase
);

    srt_div_pkg::srt_phase_t next_phase;

    always_comb begin
        next_phase = phase;
        case (phase)
            srt_div_pkg::IDLE: begin
                if (req) begin
                    next_phase = srt_div_pkg::LOAD;
                end
            end
            srt_div_pkg::LOAD: begin
                next_phase = srt_div_pkg::NORMALIZE;
            end
            srt_div_pkg::NORMALIZE: begin
                // divide by zero wins over the short path
                if (div_by_zero) begin
                    next_phase = srt_div_pkg::FINISH_ZERO;
                end else if (short_path) begin
                    next_phase = srt_div_pkg::FINISH_SHORT;
                end else begin
                    next_phase = srt_div_pkg::ITERATE;
                end
            end
            srt_div_pkg::ITERATE: begin
                if (iter_done) begin
                    next_phase = srt_div_pkg::FINISH;
                end
            end
            srt_div_pkg::FINISH,
            srt_div_pkg::FINISH_SHORT,
            srt_div_pkg::FINISH_ZERO: begin
                next_phase = srt_div_pkg::HOLD;
            end
            srt_div_pkg::HOLD: begin
                if (!req) begin
                    next_phase = srt_div_pkg::IDLE;
                end
            end
            default: begin
                next_phase = srt_div_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= srt_div_pkg::IDLE;
            ack   <= 1'b0;
        end else begin
            phase <= next_phase;
            ack   <= (next_phase == srt_div_pkg::HOLD);
        end
    end

    a_ack_needs_req : assert property (
        @(posedge clk) disable iff (reset) $rose(ack) |-> $past(req)
    ) else $error("ack rose without a pending req");

    a_hold_while_req : assert property (
        @(posedge clk) disable iff (reset)
        (phase == srt_div_pkg::HOLD && req) |=> phase == srt_div_pkg::HOLD
    ) else $error("left HOLD while req still high");

endmodule

`default_nettype wire

// File: logic/srt_result.sv
// final remainder correction, denormalization, sign fix-up and result registers
`timescale 1ns/1ps
`default_nettype none

module srt_result #(
    parameter int WIDTH = srt_div_pkg::DATA_WIDTH
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  srt_div_pkg::srt_phase_t                    phase,
    input  logic [WIDTH-1:0]                           dividend,
    input  logic [WIDTH:0]                             partial_rem,
    input  logic [WIDTH:0]                             norm_divisor,
    input  logic [WIDTH-1:0]                           pos_q,
    input  logic [WIDTH-1:0]                           neg_q,
    input  logic [srt_div_pkg::count_bits(WIDTH)-1:0] shift_total,
    input  logic                                       q_neg,
    input  logic                                       r_neg,
    output logic [WIDTH-1:0]                           quotient,
    output logic [WIDTH-1:0]                           remainder,
    output logic                                       div_zero
);

    logic             rem_low;
    logic [WIDTH:0]   fixed_rem;
    logic [WIDTH:0]   shifted_rem;
    logic [WIDTH-1:0] q_mag;
    logic [WIDTH-1:0] r_mag;

    // negative remainder means one digit too many was taken
    assign rem_low     = partial_rem[WIDTH];
    assign fixed_rem   = rem_low ? partial_rem + norm_divisor : partial_rem;
    assign shifted_rem = fixed_rem >> shift_total;
    assign r_mag       = shifted_rem[WIDTH-1:0];
    assign q_mag       = pos_q - neg_q - WIDTH'(rem_low);

    always_ff @(posedge clk) begin
        if (reset) begin
            quotient  <= '0;
            remainder <= '0;
            div_zero  <= 1'b0;
        end else begin
            case (phase)
                srt_div_pkg::FINISH: begin
                    quotient  <= q_neg ? -q_mag : q_mag;
                    remainder <= r_neg ? -r_mag : r_mag;
                    div_zero  <= 1'b0;
                end
                srt_div_pkg::FINISH_SHORT: begin
                    quotient  <= '0;
                    remainder <= dividend;
                    div_zero  <= 1'b0;
                end
                srt_div_pkg::FINISH_ZERO: begin
                    quotient  <= '1;
                    remainder <= dividend;
                    div_zero  <= 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/srt_iterate.sv
// radix-2 SRT recurrence with digit selection on the partial remainder and quotient digits
`timescale 1ns/1ps
`default_nettype none

module srt_iterate #(
    parameter int WIDTH = srt_div_pkg::DATA_WIDTH
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  srt_div_pkg::srt_phase_t                    phase,
    input  logic [WIDTH:0]                             norm_dividend,
    input  logic [WIDTH:0]                             norm_divisor,
    input  logic [srt_div_pkg::count_bits(WIDTH)-1:0] rounds,
    output logic                                       iter_done,
    output logic [WIDTH:0]                             partial_rem,
    output logic [WIDTH-1:0]                           pos_q,
    output logic [WIDTH-1:0]                           neg_q
);

    localparam int CW = srt_div_pkg::count_bits(WIDTH);

    logic [CW-1:0]  counter;
    logic [WIDTH:0] div_reg;
    logic [WIDTH:0] neg_div;
    logic [WIDTH:0] next_rem;
    logic           digit_pos;
    logic           digit_neg;

    assign iter_done = (counter == rounds);

    // digit from the top two bits of the remainder
    always_comb begin
        next_rem  = partial_rem;
        digit_pos = 1'b0;
        digit_neg = 1'b0;
        case (partial_rem[WIDTH:WIDTH-1])
            2'b01: begin
                next_rem  = partial_rem + neg_div;
                digit_pos = 1'b1;
            end
            2'b10: begin
                next_rem  = partial_rem + div_reg;
                digit_neg = 1'b1;
            end
            default: begin
                next_rem = partial_rem;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
        end else if (phase == srt_div_pkg::NORMALIZE) begin
            counter <= '0;
        end else if (phase == srt_div_pkg::ITERATE) begin
            counter <= counter + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == srt_div_pkg::NORMALIZE) begin
            partial_rem <= norm_dividend;
            div_reg     <= norm_divisor;
            neg_div     <= -norm_divisor;
            pos_q       <= '0;
            neg_q       <= '0;
        end else if (phase == srt_div_pkg::ITERATE) begin
            // last round keeps the remainder aligned with the divisor
            partial_rem <= iter_done ? next_rem : next_rem << 1;
            pos_q       <= {pos_q[WIDTH-2:0], digit_pos};
            neg_q       <= {neg_q[WIDTH-2:0], digit_neg};
        end
    end

    a_counter_bound : assert property (
        @(posedge clk) disable iff (reset)
        phase == srt_div_pkg::ITERATE |-> counter <= rounds
    ) else $error("iteration counter passed the round count");

endmodule

`default_nettype wire

// File: logic/srt_operand_prep.sv
// operand capture, magnitude and sign forming, normalization and early-exit detection
`timescale 1ns/1ps
`default_nettype none

module srt_operand_prep #(
    parameter int WIDTH = srt_div_pkg::DATA_WIDTH
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  srt_div_pkg::srt_phase_t                    phase,
    input  logic [WIDTH-1:0]                           dividend,
    input  logic [WIDTH-1:0]                           divisor,
    input  logic                                       is_signed,
    output logic                                       div_by_zero,
    output logic                                       short_path,
    output logic [WIDTH:0]                             norm_dividend,
    output logic [WIDTH:0]                             norm_divisor,
    output logic [srt_div_pkg::count_bits(WIDTH)-1:0] rounds,
    output logic [srt_div_pkg::count_bits(WIDTH)-1:0] shift_total,
    output logic                                       q_neg,
    output logic                                       r_neg
);

    localparam int CW = srt_div_pkg::count_bits(WIDTH);

    logic          dividend_neg;
    logic          divisor_neg;
    logic [WIDTH-1:0] mag_dividend;
    logic [WIDTH-1:0] mag_divisor;
    logic [CW-1:0] s_zero;
    logic [CW-1:0] d_zero;
    logic [CW:0]   delta;

    assign dividend_neg = is_signed & dividend[WIDTH-1];
    assign divisor_neg  = is_signed & divisor[WIDTH-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            q_neg <= 1'b0;
            r_neg <= 1'b0;
        end else if (phase == srt_div_pkg::LOAD) begin
            q_neg <= dividend_neg ^ divisor_neg;
            r_neg <= dividend_neg;
        end
    end

    // most negative value maps onto its own unsigned magnitude
    always_ff @(posedge clk) begin
        if (phase == srt_div_pkg::LOAD) begin
            mag_dividend <= dividend_neg ? -dividend : dividend;
            mag_divisor  <= divisor_neg ? -divisor : divisor;
        end
    end

    srt_lzc #(.WIDTH(WIDTH)) u_lzc_dividend (
        .data       (mag_dividend),
        .zero_count (s_zero)
    );

    srt_lzc #(.WIDTH(WIDTH)) u_lzc_divisor (
        .data       (mag_divisor),
        .zero_count (d_zero)
    );

    // one extra bit so the sign of the difference is never ambiguous
    assign delta = {1'b0, d_zero} - {1'b0, s_zero};

    assign div_by_zero   = (d_zero == CW'(WIDTH));
    assign short_path    = delta[CW];
    assign rounds        = delta[CW-1:0];
    assign shift_total   = rounds + s_zero;
    assign norm_dividend = {1'b0, mag_dividend << s_zero};
    assign norm_divisor  = {1'b0, mag_divisor << d_zero};

endmodule

`default_nettype wire

// File: logic/srt_lzc.sv
// combinational leading-zero counter built as a recursive binary split of the input word
`timescale 1ns/1ps
`default_nettype none

module srt_lzc #(
    parameter int WIDTH = srt_div_pkg::DATA_WIDTH
) (
    input  logic [WIDTH-1:0]                           data,
    output logic [srt_div_pkg::count_bits(WIDTH)-1:0] zero_count
);

    localparam int CW = srt_div_pkg::count_bits(WIDTH);

    generate
        if (WIDTH == 1) begin : g_leaf
            assign zero_count = ~data[0];
        end else begin : g_split
            localparam int HALF = WIDTH / 2;
            localparam int HCW  = srt_div_pkg::count_bits(HALF);

            logic [HCW-1:0] hi_count;
            logic [HCW-1:0] lo_count;

            srt_lzc #(.WIDTH(HALF)) u_hi (
                .data       (data[WIDTH-1:HALF]),
                .zero_count (hi_count)
            );

            srt_lzc #(.WIDTH(HALF)) u_lo (
                .data       (data[HALF-1:0]),
                .zero_count (lo_count)
            );

            // top bit of a half count only set when that half is all zeros
            assign zero_count = hi_count[HCW-1] ? {1'b0, lo_count} + CW'(HALF)
                                                : {1'b0, hi_count};
        end
    endgenerate

    // count must point at the leading one and never pass WIDTH
    a_count_range : assert final ($isunknown(data) ||
        (zero_count == WIDTH ? data == '0
                             : (data >> (WIDTH - 1 - zero_count)) == 1))
        else $error("leading zero count %0d does not match data %h", zero_count, data);

endmodule

`default_nettype wire

// File: logic/srt_div_pkg.sv
// shared width defaults, count-width helper and phase encoding for the SRT divider RTL
`default_nettype none

package srt_div_pkg;

    // default operand width for the top level
    parameter int DATA_WIDTH = 32;

    // width of a leading-zero count that can hold the value width itself
    function automatic int count_bits(input int width);
        return $clog2(width) + 1;
    endfunction

    // one control phase per state of the sequencer
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        NORMALIZE,
        ITERATE,
        FINISH,
        FINISH_SHORT,
        FINISH_ZERO,
        HOLD
    } srt_phase_t;

endpackage

`default_nettype wire
